//--- logic/axi_delay_defines.svh
// Field widths of the delayed AXI bus
// Default delay settings for the request and response channels

`ifndef AXI_DELAY_DEFINES_SVH
`define AXI_DELAY_DEFINES_SVH

// AXI field widths
`define AXI_DLY_ID_W   4
`define AXI_DLY_ADDR_W 32
`define AXI_DLY_DATA_W 32
`define AXI_DLY_USER_W 2

// LFSR bits that form one random stall of 0 to 7 cycles
`define AXI_DLY_STALL_BITS 3

// Request channels AW, W and AR
`define AXI_DLY_IN_RANDOM 0
`define AXI_DLY_IN_FIXED  2

// Response channels B and R
`define AXI_DLY_OUT_RANDOM 1
// Only takes effect with random stalls off
`define AXI_DLY_OUT_FIXED  1

`endif

//--- logic/axi_delay_pkg.sv
// AXI field types, channel payloads and request/response bundles
// State encoding of one delay stage

`include "axi_delay_defines.svh"

package axi_delay_pkg;

  // Field vectors
  typedef logic [`AXI_DLY_ID_W-1:0]     id_t;
  typedef logic [`AXI_DLY_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_DLY_DATA_W-1:0]   data_t;
  typedef logic [`AXI_DLY_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_DLY_USER_W-1:0]   user_t;

  // Fixed AXI4 encodings
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_code_t;

  // Write address
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    user_t  user;
  } aw_chan_t;

  // Write data
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } w_chan_t;

  // Write response
  typedef struct packed {
    id_t        id;
    resp_code_t resp;
    user_t      user;
  } b_chan_t;

  // Read address with the same layout as AW
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    user_t  user;
  } ar_chan_t;

  // Read data
  typedef struct packed {
    id_t        id;
    data_t      data;
    resp_code_t resp;
    logic       last;
    user_t      user;
  } r_chan_t;

  // Everything a master drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything a slave drives
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // Stage states
  typedef enum logic [1:0] {
    IDLE,
    COUNT,
    PASS
  } delay_state_e;

endpackage

//--- logic/stall_lfsr.sv
// 16-bit Galois LFSR stepped on demand
// Supplies the random stall counts of one delay stage

module stall_lfsr #(
  parameter logic [15:0] Seed = 16'hace1
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        step_i,
  output logic [15:0] value_o
);

  // Taps 16, 14, 13 and 11 in right-shift form
  localparam logic [15:0] TapMask = 16'hb400;

  logic [15:0] state_q;
  logic [15:0] state_d;

  // An all-zero seed would lock the register
  if (Seed == 16'h0000) begin : gen_seed_check
    $error("stall_lfsr needs a nonzero Seed");
  end

  // Shift right and fold the taps back in when a one drops out
  assign state_d = {1'b0, state_q[15:1]} ^ (state_q[0] ? TapMask : 16'h0000);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Seed;
    end else if (step_i) begin
      state_q <= state_d;
    end
  end

  assign value_o = state_q;

  // Maximal-length sequence keeps away from zero across every step
  a_never_zero : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    state_q != 16'h0000
  ) else $error("stall_lfsr reached the all-zero state");

endmodule

//--- logic/stream_delay.sv
// One valid/ready stage that holds back each beat for a fixed or random count
// Payload passes straight through and the handshake is coupled on both sides

`include "axi_delay_defines.svh"

module stream_delay #(
  parameter type         payload_t   = logic,
  parameter bit          StallRandom = 1'b0,
  parameter int unsigned FixedDelay  = 1,
  parameter logic [15:0] Seed        = 16'hace1
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream side
  input  payload_t payload_i,
  input  logic     valid_i,
  output logic     ready_o,
  // Downstream side
  output payload_t payload_o,
  output logic     valid_o,
  input  logic     ready_i
);

  // Largest count the stage may ever load
  localparam int unsigned MaxDelay =
    StallRandom ? (2 ** `AXI_DLY_STALL_BITS) - 1 : FixedDelay;
  localparam int unsigned CntW = (MaxDelay > 1) ? $clog2(MaxDelay + 1) : 1;

  axi_delay_pkg::delay_state_e state_q;
  axi_delay_pkg::delay_state_e state_d;

  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic [CntW-1:0] load_cnt;
  logic            load;

  // A new beat is seen while idle
  assign load = (state_q == axi_delay_pkg::IDLE) && valid_i;

  if (StallRandom) begin : gen_random
    logic [15:0] lfsr_value;

    // New draw for every loaded beat
    stall_lfsr #(
      .Seed ( Seed )
    ) stall_lfsr_i (
      .clk_i,
      .rst_n_i,
      .step_i  ( load       ),
      .value_o ( lfsr_value )
    );

    assign load_cnt = CntW'(lfsr_value[`AXI_DLY_STALL_BITS-1:0]);
  end else begin : gen_fixed
    assign load_cnt = CntW'(FixedDelay);
  end

  assign payload_o = payload_i;

  // Zero count lets the beat through in the same cycle
  assign valid_o = (state_q == axi_delay_pkg::PASS) || (load && (load_cnt == '0));
  assign ready_o = valid_o & ready_i;

  // The loaded cycle already counts as one, so the counter holds D-1
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      axi_delay_pkg::IDLE: begin
        if (valid_i) begin
          if (load_cnt == '0) begin
            // Pass-through beat that got stalled downstream
            if (!ready_i) begin
              state_d = axi_delay_pkg::PASS;
            end
          end else begin
            cnt_d = load_cnt - 1'b1;
            if (cnt_d == '0) begin
              state_d = axi_delay_pkg::PASS;
            end else begin
              state_d = axi_delay_pkg::COUNT;
            end
          end
        end
      end
      axi_delay_pkg::COUNT: begin
        cnt_d = cnt_q - 1'b1;
        if (cnt_d == '0) begin
          state_d = axi_delay_pkg::PASS;
        end
      end
      axi_delay_pkg::PASS: begin
        // Hold valid until downstream takes the beat
        if (ready_i) begin
          state_d = axi_delay_pkg::IDLE;
        end
      end
      default: begin
        state_d = axi_delay_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= axi_delay_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Upstream never sees a handshake for a beat it does not offer
  a_ready_needs_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ready_o |-> valid_i
  ) else $error("stream_delay raised ready_o without valid_i");

  // A delayed beat is not withdrawn before downstream accepts it
  a_valid_held : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o
  ) else $error("stream_delay dropped valid_o before ready_i");

endmodule

//--- logic/axi_delayer.sv
// AXI4 channel delayer between a slave and a master port
// Five independent delay stages with requests forward and responses backward

`include "axi_delay_defines.svh"

module axi_delayer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Slave port facing the upstream master
  input  axi_delay_pkg::axi_req_t  slv_req_i,
  output axi_delay_pkg::axi_resp_t slv_resp_o,
  // Master port facing the downstream slave
  output axi_delay_pkg::axi_req_t  mst_req_o,
  input  axi_delay_pkg::axi_resp_t mst_resp_i
);

  // AW
  stream_delay #(
    .payload_t   ( axi_delay_pkg::aw_chan_t ),
    .StallRandom ( `AXI_DLY_IN_RANDOM       ),
    .FixedDelay  ( `AXI_DLY_IN_FIXED        ),
    .Seed        ( 16'h1d0f                 )
  ) stream_delay_aw_i (
    .clk_i,
    .rst_n_i,
    .payload_i ( slv_req_i.aw        ),
    .valid_i   ( slv_req_i.aw_valid  ),
    .ready_o   ( slv_resp_o.aw_ready ),
    .payload_o ( mst_req_o.aw        ),
    .valid_o   ( mst_req_o.aw_valid  ),
    .ready_i   ( mst_resp_i.aw_ready )
  );

  // W
  stream_delay #(
    .payload_t   ( axi_delay_pkg::w_chan_t ),
    .StallRandom ( `AXI_DLY_IN_RANDOM      ),
    .FixedDelay  ( `AXI_DLY_IN_FIXED       ),
    .Seed        ( 16'h3a5c                )
  ) stream_delay_w_i (
    .clk_i,
    .rst_n_i,
    .payload_i ( slv_req_i.w        ),
    .valid_i   ( slv_req_i.w_valid  ),
    .ready_o   ( slv_resp_o.w_ready ),
    .payload_o ( mst_req_o.w        ),
    .valid_o   ( mst_req_o.w_valid  ),
    .ready_i   ( mst_resp_i.w_ready )
  );

  // AR
  stream_delay #(
    .payload_t   ( axi_delay_pkg::ar_chan_t ),
    .StallRandom ( `AXI_DLY_IN_RANDOM       ),
    .FixedDelay  ( `AXI_DLY_IN_FIXED        ),
    .Seed        ( 16'h77e1                 )
  ) stream_delay_ar_i (
    .clk_i,
    .rst_n_i,
    .payload_i ( slv_req_i.ar        ),
    .valid_i   ( slv_req_i.ar_valid  ),
    .ready_o   ( slv_resp_o.ar_ready ),
    .payload_o ( mst_req_o.ar        ),
    .valid_o   ( mst_req_o.ar_valid  ),
    .ready_i   ( mst_resp_i.ar_ready )
  );

  // B back toward the slave port
  stream_delay #(
    .payload_t   ( axi_delay_pkg::b_chan_t ),
    .StallRandom ( `AXI_DLY_OUT_RANDOM     ),
    .FixedDelay  ( `AXI_DLY_OUT_FIXED      ),
    .Seed        ( 16'hb2c4                )
  ) stream_delay_b_i (
    .clk_i,
    .rst_n_i,
    .payload_i ( mst_resp_i.b       ),
    .valid_i   ( mst_resp_i.b_valid ),
    .ready_o   ( mst_req_o.b_ready  ),
    .payload_o ( slv_resp_o.b       ),
    .valid_o   ( slv_resp_o.b_valid ),
    .ready_i   ( slv_req_i.b_ready  )
  );

  // R with its own seed so B and R stall apart
  stream_delay #(
    .payload_t   ( axi_delay_pkg::r_chan_t ),
    .StallRandom ( `AXI_DLY_OUT_RANDOM     ),
    .FixedDelay  ( `AXI_DLY_OUT_FIXED      ),
    .Seed        ( 16'he90b                )
  ) stream_delay_r_i (
    .clk_i,
    .rst_n_i,
    .payload_i ( mst_resp_i.r       ),
    .valid_i   ( mst_resp_i.r_valid ),
    .ready_o   ( mst_req_o.r_ready  ),
    .payload_o ( slv_resp_o.r       ),
    .valid_o   ( slv_resp_o.r_valid ),
    .ready_i   ( slv_req_i.r_ready  )
  );

endmodule

//--- bench/tb_axi_delayer.sv
// Testbench for the AXI channel delayer
// Random traffic on both ports, per-channel queue models, delay and handshake checks

`include "axi_delay_defines.svh"

module tb_axi_delayer;

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 10;
  localparam int IdleCycles  = 5;
  localparam int NumBeats    = 300;
  localparam int NumCh       = 5;
  localparam int MaxGap      = 8;
  localparam int MaxStall    = (2 ** `AXI_DLY_STALL_BITS) - 1;
  localparam int Timeout     = NumBeats * (MaxStall + MaxGap) * 2 * ClkPeriod
                               + (ResetCycles + IdleCycles) * ClkPeriod;

  // Payload widths of the five channels
  localparam int AwW = $bits(axi_delay_pkg::aw_chan_t);
  localparam int WW  = $bits(axi_delay_pkg::w_chan_t);
  localparam int ArW = $bits(axi_delay_pkg::ar_chan_t);
  localparam int BW  = $bits(axi_delay_pkg::b_chan_t);
  localparam int RW  = $bits(axi_delay_pkg::r_chan_t);

  logic clk_i;
  logic rst_n_i;

  axi_delay_pkg::axi_req_t  slv_req;
  axi_delay_pkg::axi_resp_t slv_resp;
  axi_delay_pkg::axi_req_t  mst_req;
  axi_delay_pkg::axi_resp_t mst_resp;

  integer seed;
  int     errors;
  int     cyc;

  // Channel index order is aw, w, ar, b, r
  logic        src_valid  [NumCh];
  logic [63:0] src_pay    [NumCh];
  logic        sink_ready [NumCh];
  int          issued     [NumCh];
  int          gap        [NumCh];

  // Handshake as seen on both sides of each stage
  logic        in_valid  [NumCh];
  logic        in_ready  [NumCh];
  logic [63:0] in_pay    [NumCh];
  logic        out_valid [NumCh];
  logic        out_ready [NumCh];
  logic [63:0] out_pay   [NumCh];
  logic        xfer      [NumCh];

  // Reference model per channel
  logic [63:0] model_q   [NumCh][$];
  int          in_count  [NumCh];
  int          out_count [NumCh];
  logic        busy      [NumCh];
  logic        seen      [NumCh];
  int          start     [NumCh];
  logic        held      [NumCh];
  logic [63:0] held_pay  [NumCh];

  axi_delayer axi_delayer_i (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .slv_req_i  ( slv_req  ),
    .slv_resp_o ( slv_resp ),
    .mst_req_o  ( mst_req  ),
    .mst_resp_i ( mst_resp )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic string chan_name(input int ch);
    case (ch)
      0:       return "aw";
      1:       return "w";
      2:       return "ar";
      3:       return "b";
      default: return "r";
    endcase
  endfunction

  // Requests use the input settings and responses the output settings
  function automatic bit stall_random(input int ch);
    if (ch < 3) return `AXI_DLY_IN_RANDOM != 0;
    return `AXI_DLY_OUT_RANDOM != 0;
  endfunction

  function automatic int fixed_delay(input int ch);
    if (ch < 3) return `AXI_DLY_IN_FIXED;
    return `AXI_DLY_OUT_FIXED;
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic int rand_below(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cyc);
    end
  endtask

  task automatic apply_inputs();
    slv_req.aw_valid  = src_valid[0];
    slv_req.aw        = src_pay[0][AwW-1:0];
    slv_req.w_valid   = src_valid[1];
    slv_req.w         = src_pay[1][WW-1:0];
    slv_req.ar_valid  = src_valid[2];
    slv_req.ar        = src_pay[2][ArW-1:0];
    mst_resp.b_valid  = src_valid[3];
    mst_resp.b        = src_pay[3][BW-1:0];
    mst_resp.r_valid  = src_valid[4];
    mst_resp.r        = src_pay[4][RW-1:0];
    mst_resp.aw_ready = sink_ready[0];
    mst_resp.w_ready  = sink_ready[1];
    mst_resp.ar_ready = sink_ready[2];
    slv_req.b_ready   = sink_ready[3];
    slv_req.r_ready   = sink_ready[4];
  endtask

  task automatic sample_channels();
    in_valid[0]  = slv_req.aw_valid;
    in_ready[0]  = slv_resp.aw_ready;
    in_pay[0]    = 64'(slv_req.aw);
    out_valid[0] = mst_req.aw_valid;
    out_ready[0] = mst_resp.aw_ready;
    out_pay[0]   = 64'(mst_req.aw);
    in_valid[1]  = slv_req.w_valid;
    in_ready[1]  = slv_resp.w_ready;
    in_pay[1]    = 64'(slv_req.w);
    out_valid[1] = mst_req.w_valid;
    out_ready[1] = mst_resp.w_ready;
    out_pay[1]   = 64'(mst_req.w);
    in_valid[2]  = slv_req.ar_valid;
    in_ready[2]  = slv_resp.ar_ready;
    in_pay[2]    = 64'(slv_req.ar);
    out_valid[2] = mst_req.ar_valid;
    out_ready[2] = mst_resp.ar_ready;
    out_pay[2]   = 64'(mst_req.ar);
    // Responses enter at the master port
    in_valid[3]  = mst_resp.b_valid;
    in_ready[3]  = mst_req.b_ready;
    in_pay[3]    = 64'(mst_resp.b);
    out_valid[3] = slv_resp.b_valid;
    out_ready[3] = slv_req.b_ready;
    out_pay[3]   = 64'(slv_resp.b);
    in_valid[4]  = mst_resp.r_valid;
    in_ready[4]  = mst_req.r_ready;
    in_pay[4]    = 64'(mst_resp.r);
    out_valid[4] = slv_resp.r_valid;
    out_ready[4] = slv_req.r_ready;
    out_pay[4]   = 64'(slv_resp.r);
  endtask

  // Sources hold a beat until it transfers and then idle for 0 to MaxGap cycles
  task automatic drive_sources();
    int ch;
    for (ch = 0; ch < NumCh; ch++) begin
      if (src_valid[ch] && xfer[ch]) begin
        src_valid[ch] = 1'b0;
        gap[ch]       = rand_below(MaxGap + 1);
      end
      if (!src_valid[ch]) begin
        if (gap[ch] > 0) begin
          gap[ch]--;
        end else if (issued[ch] < NumBeats) begin
          src_valid[ch] = 1'b1;
          src_pay[ch]   = rand64();
          issued[ch]++;
        end
      end
      sink_ready[ch] = (rand_below(4) != 0);
    end
    apply_inputs();
  endtask

  task automatic observe_cycle();
    int          ch;
    int          lat;
    logic [63:0] exp_pay;
    sample_channels();
    for (ch = 0; ch < NumCh; ch++) begin
      check_value({chan_name(ch), " input ready"}, 64'(in_ready[ch]),
                  64'(out_valid[ch] & out_ready[ch]));
      xfer[ch] = in_valid[ch] & in_ready[ch];
      // A stalled beat stays offered and unchanged
      if (held[ch]) begin
        check_value({chan_name(ch), " valid under back-pressure"}, 64'(out_valid[ch]), 64'(1));
        check_value({chan_name(ch), " payload under back-pressure"}, out_pay[ch], held_pay[ch]);
      end
      held[ch]     = out_valid[ch] & ~out_ready[ch];
      held_pay[ch] = out_pay[ch];
      // Stage loads only while idle
      if (!busy[ch] && in_valid[ch]) begin
        busy[ch]  = 1'b1;
        seen[ch]  = 1'b0;
        start[ch] = cyc;
      end
      if (!busy[ch]) begin
        check_value({chan_name(ch), " output valid while idle"}, 64'(out_valid[ch]), 64'(0));
      end else if (out_valid[ch] && !seen[ch]) begin
        seen[ch] = 1'b1;
        lat      = cyc - start[ch];
        if (stall_random(ch)) begin
          check_value({chan_name(ch), " delay within stall bound"}, 64'(lat <= MaxStall),
                      64'(1));
        end else begin
          check_value({chan_name(ch), " delay"}, 64'(lat), 64'(fixed_delay(ch)));
        end
      end
      if (xfer[ch]) begin
        model_q[ch].push_back(in_pay[ch]);
        in_count[ch]++;
      end
      if (out_valid[ch] && out_ready[ch]) begin
        out_count[ch]++;
        busy[ch] = 1'b0;
        if (model_q[ch].size() == 0) begin
          errors++;
          $display("%s beat left the delayer with no beat outstanding", chan_name(ch));
        end else begin
          exp_pay = model_q[ch].pop_front();
          check_value({chan_name(ch), " payload"}, out_pay[ch], exp_pay);
        end
      end
    end
  endtask

  function automatic bit all_done();
    int ch;
    for (ch = 0; ch < NumCh; ch++) begin
      if (out_count[ch] < NumBeats) return 1'b0;
    end
    return 1'b1;
  endfunction

  initial begin
    int ch;
    seed    = 32'heee01538;
    errors  = 0;
    cyc     = 0;
    clk_i   = 1'b0;
    rst_n_i = 1'b0;
    for (ch = 0; ch < NumCh; ch++) begin
      src_valid[ch]  = 1'b0;
      src_pay[ch]    = '0;
      sink_ready[ch] = 1'b0;
      issued[ch]     = 0;
      gap[ch]        = 0;
      xfer[ch]       = 1'b0;
      in_count[ch]   = 0;
      out_count[ch]  = 0;
      start[ch]      = 0;
      busy[ch]       = 1'b0;
      seen[ch]       = 1'b0;
      held[ch]       = 1'b0;
      held_pay[ch]   = '0;
    end
    apply_inputs();
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Downstream ready with nothing offered keeps every output low
    for (ch = 0; ch < NumCh; ch++) begin
      sink_ready[ch] = 1'b1;
    end
    apply_inputs();
    repeat (IdleCycles) begin
      @(negedge clk_i);
      #1;
      sample_channels();
      for (ch = 0; ch < NumCh; ch++) begin
        check_value({chan_name(ch), " output valid after reset"}, 64'(out_valid[ch]), 64'(0));
        check_value({chan_name(ch), " input ready after reset"}, 64'(in_ready[ch]), 64'(0));
      end
    end

    while (!all_done()) begin
      @(negedge clk_i);
      drive_sources();
      #1;
      observe_cycle();
      cyc++;
    end

    for (ch = 0; ch < NumCh; ch++) begin
      check_value({chan_name(ch), " beat count"}, 64'(out_count[ch]), 64'(in_count[ch]));
      check_value({chan_name(ch), " beats left in model"}, 64'(model_q[ch].size()), 64'(0));
    end
    $display("Run finished after %0d cycles with %0d errors, %0d beats per channel",
             cyc, errors, NumBeats);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog sized from beat count, worst stall and worst gap
  initial begin
    #(Timeout);
    $display("Watchdog expired before all channels finished their traffic");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- project.f
+incdir+logic
logic/axi_delay_pkg.sv
logic/stall_lfsr.sv
logic/stream_delay.sv
logic/axi_delayer.sv
bench/tb_axi_delayer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI delayer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_axi_delayer \
  -o sim_axi_delayer

output=$(./obj_dir/sim_axi_delayer)
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
